// ==== compile.f ====
avm_pkg.sv
rsa_pkg.sv
byte_fifo.sv
serial_port_regs.sv
rsa_modexp_core.sv
rsa_wrapper.sv
rsa_top.sv
tb_rsa_top_sva.sv
tb_rsa_top.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_rsa_top
FILELIST  = compile.f
BUILD_DIR = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the simulation"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_rsa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_top;

    localparam int bitwidth       = 32;
    localparam int fifo_depth     = 4;
    localparam int n_blocks       = 4;
    localparam int n_rx           = 8 + 4 * n_blocks;  // n, d, then the blocks
    localparam int n_tx           = 3 * n_blocks;
    localparam int timeout_cycles = n_blocks * 2 * bitwidth * (bitwidth + 2) + 2000;
    localparam int stall_cycles   = 3000;  // long enough to fill the tx fifo

    localparam logic [31:0] key_n = 32'h00C5_1F3B;
    localparam logic [31:0] key_d = 32'h0001_2345;

    logic        avm_clk;
    logic        avm_rst;
    logic [7:0]  rx_data;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready;
    logic        reset_done = 1'b0;
    logic [31:0] lfsr;
    logic [31:0] blocks  [n_blocks];
    logic [7:0]  rx_seq  [n_rx];
    logic [7:0]  exp_seq [n_tx];
    int          tx_idx  = 0;
    int          rx_idx  = 0;
    int          rx_in   = 0;  // bytes accepted on the rx stream
    int          cycles  = 0;

    rsa_top #(.bitwidth(bitwidth), .fifo_depth(fifo_depth)) i_rsa_top (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    bind rsa_top tb_rsa_top_sva rsa_checks (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_waitrequest (avm_waitrequest),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready),
        .wrap_state      (i_wrapper.state_r)
    );

    always #50 avm_clk = ~avm_clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_mismatch(input string msg);
        stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s", $time, msg));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int nbits, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[6:0], lfsr[0]};
        end
    endtask

    // plain square-and-multiply, operands stay below 2^24
    function automatic logic [63:0] mod_pow(input logic [63:0] base, input logic [63:0] e,
                                            input logic [63:0] m);
        logic [63:0] r;
        logic [63:0] b;
        r = 64'd1 % m;
        b = base % m;
        while (e != 64'd0) begin
            if (e[0]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
            e = e >> 1;
        end
        return r;
    endfunction

    task automatic build_vectors();
        logic [63:0] r;
        blocks[0] = 32'h0012_3456;
        blocks[1] = 32'h0000_0000;  // zero in, zero out
        blocks[2] = 32'h0000_0001;  // one in, one out
        blocks[3] = 32'h00AB_CDEF;
        for (int i = 0; i < 4; i++) begin
            rx_seq[i]     = key_n[31-8*i -: 8];
            rx_seq[4 + i] = key_d[31-8*i -: 8];
        end
        for (int b = 0; b < n_blocks; b++) begin
            for (int i = 0; i < 4; i++) begin
                rx_seq[8 + 4*b + i] = blocks[b][31-8*i -: 8];
            end
            r = mod_pow({32'd0, blocks[b]}, {32'd0, key_d}, {32'd0, key_n});
            for (int k = 0; k < 3; k++) begin
                exp_seq[3*b + k] = r[23-8*k -: 8];  // top byte is never sent
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input logic [7:0] b);
        rx_data  = b;
        rx_valid = 1'b1;
        while (!rx_ready) begin
            @(negedge avm_clk);
        end
        @(negedge avm_clk);
        rx_valid = 1'b0;
    endtask

    initial begin : rx_sender
        logic [7:0] gap;
        wait (reset_done);
        for (int i = 0; i < n_rx; i++) begin
            if (i >= 8) begin  // key goes back to back, blocks get random gaps
                take_bits(2, gap);
                if (gap == 8'd0) begin
                    @(negedge avm_clk);
                end
            end
            send_byte(rx_seq[i]);
        end
    end

    always @(negedge avm_clk) begin : tx_ready_drive
        logic [7:0] bits;
        if (avm_rst || cycles < stall_cycles) begin
            tx_ready = 1'b0;
        end else begin
            take_bits(2, bits);
            tx_ready = (bits != 8'd0);  // low one cycle in four
        end
    end

    always @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            tx_idx <= 0;
            rx_idx <= 0;
            rx_in  <= 0;
        end else begin
            if (tx_valid && tx_ready) begin
                tx_idx <= tx_idx + 1;
            end
            if (rx_valid && rx_ready) begin
                rx_in <= rx_in + 1;
            end
            if (i_rsa_top.i_port.rx_pop) begin
                rx_idx <= rx_idx + 1;
            end
        end
    end

    always @(posedge avm_clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            stop_with_failure($sformatf("timeout after %0d cycles, only %0d of %0d bytes sent",
                                        cycles, tx_idx, n_tx));
        end
    end

    always @(negedge avm_clk) begin
        if (i_rsa_top.rsa_checks.fail_cnt != 0) begin
            stop_with_failure("a bound Avalon or stream assertion failed");
        end
    end

    a_tx_count: assert property (@(posedge avm_clk) disable iff (avm_rst)
        tx_valid && tx_ready |-> tx_idx < n_tx)
        else stop_with_failure("more tx bytes came out than were expected");

    a_tx_data: assert property (@(posedge avm_clk) disable iff (avm_rst)
        tx_valid && tx_ready |-> tx_data == exp_seq[tx_idx])
        else value_mismatch($sformatf("tx byte %0d is %02h, expected %02h",
                            $sampled(tx_idx), $sampled(tx_data), exp_seq[$sampled(tx_idx)]));

    // ready only while fewer than fifo_depth bytes wait unread
    a_rx_flow: assert property (@(posedge avm_clk) disable iff (avm_rst)
        rx_ready == ((rx_in - rx_idx) < fifo_depth))
        else value_mismatch($sformatf("rx_ready is %0b with %0d bytes waiting",
                            $sampled(rx_ready), $sampled(rx_in) - $sampled(rx_idx)));

    // wrapper must see the rx bytes in the order they were sent
    a_rx_order: assert property (@(posedge avm_clk) disable iff (avm_rst)
        i_rsa_top.i_port.rx_pop |-> i_rsa_top.avm_readdata[7:0] == rx_seq[rx_idx])
        else value_mismatch($sformatf("rx byte %0d read as %02h, expected %02h",
                            $sampled(rx_idx), $sampled(i_rsa_top.avm_readdata[7:0]),
                            rx_seq[$sampled(rx_idx)]));

    initial begin
        avm_clk  = 1'b0;
        avm_rst  = 1'b1;
        rx_data  = 8'd0;
        rx_valid = 1'b0;
        tx_ready = 1'b0;
        lfsr     = 32'h57a0_6c88;
        build_vectors();
        repeat (10) @(negedge avm_clk);
        avm_rst    = 1'b0;
        reset_done = 1'b1;
        while (tx_idx != n_tx) begin
            @(negedge avm_clk);
        end
        repeat (200) @(negedge avm_clk);  // room for a stray extra byte
        if (rx_idx == n_rx && tx_idx == n_tx) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            value_mismatch($sformatf("byte counts rx %0d of %0d, tx %0d of %0d",
                                     rx_idx, n_rx, tx_idx, n_tx));
        end
    end

endmodule

`default_nettype wire

// ==== tb_rsa_top_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rsa_top_sva (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    input  logic [avm_pkg::avm_addr_w-1:0] avm_address,
    input  logic                           avm_read,
    input  logic                           avm_write,
    input  logic                           avm_waitrequest,
    input  logic [7:0]                     tx_data,
    input  logic                           tx_valid,
    input  logic                           tx_ready,
    input  rsa_pkg::wrap_state_t           wrap_state
);
    import rsa_pkg::*;

    int fail_cnt = 0;  // watched from the testbench top

    // master never mixes a read and a write
    a_no_rd_wr: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("avm_read and avm_write high in the same cycle");
        end

    a_hold_req: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_waitrequest |=> $stable(avm_address) && $stable(avm_read) && $stable(avm_write))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("Avalon request changed while waitrequest was high");
        end

    a_reset_quiet: assert property (@(posedge avm_clk)
        (avm_rst || $fell(avm_rst)) |-> !tx_valid && !avm_read && !avm_write)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("bus or tx stream active in or right after reset");
        end

    // stalled tx byte must not move
    a_tx_hold: assert property (@(posedge avm_clk) disable iff (avm_rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("tx byte dropped or changed while tx_ready was low");
        end

    a_calc_idle: assert property (@(posedge avm_clk) disable iff (avm_rst)
        wrap_state == wait_calc |-> !avm_read && !avm_write)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("bus access while the core is running");
        end

    a_write_in_send: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> wrap_state == send_data)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("write outside the send state");
        end

endmodule

`default_nettype wire

// ==== rsa_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_top #(
    parameter int bitwidth   = rsa_pkg::default_bitwidth,
    parameter int fifo_depth = 4
) (
    input  logic       avm_clk,
    input  logic       avm_rst,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic       rx_ready,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);
    import avm_pkg::*;

    // avalon bus, wrapper is master
    logic [avm_addr_w-1:0] avm_address;
    logic                  avm_read;
    logic                  avm_write;
    logic [31:0]           avm_writedata;
    logic [31:0]           avm_readdata;
    logic                  avm_waitrequest;

    serial_port_regs #(.fifo_depth(fifo_depth)) i_port (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .tx_ready        (tx_ready)
    );

    rsa_wrapper #(.bitwidth(bitwidth)) i_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest)
    );

endmodule

`default_nettype wire

// ==== rsa_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_wrapper #(
    parameter int bitwidth = rsa_pkg::default_bitwidth
) (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    output logic [avm_pkg::avm_addr_w-1:0] avm_address,
    output logic                          avm_read,
    output logic                          avm_write,
    output logic [31:0]                   avm_writedata,
    input  logic [31:0]                   avm_readdata,
    input  logic                          avm_waitrequest
);
    import avm_pkg::*;
    import rsa_pkg::*;

    localparam int nbytes = bitwidth / 8;
    localparam int cnt_w  = $clog2(nbytes);

    wrap_state_t           state_r;
    wrap_state_t           state_w;
    logic [cnt_w-1:0]      byte_cnt_r;
    logic [cnt_w-1:0]      byte_cnt_w;
    logic [avm_addr_w-1:0] addr_r;
    logic [avm_addr_w-1:0] addr_w;
    logic                  read_r;
    logic                  read_w;
    logic                  write_r;
    logic                  write_w;
    logic                  start_r;
    logic                  start_w;
    logic [bitwidth-1:0]   n_r;
    logic [bitwidth-1:0]   n_w;
    logic [bitwidth-1:0]   d_r;
    logic [bitwidth-1:0]   d_w;
    logic [bitwidth-1:0]   enc_r;      // ciphertext
    logic [bitwidth-1:0]   enc_w;
    logic [bitwidth-1:0]   dec_r;      // plaintext, shifted out msb first
    logic [bitwidth-1:0]   dec_w;
    logic [bitwidth-1:0]   core_result;
    logic                  core_finished;
    logic                  acc_done;
    logic                  last_rx;
    logic                  last_tx;

    assign avm_address   = addr_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {24'd0, dec_r[bitwidth-9 -: 8]};  // top byte is never sent

    assign acc_done = (read_r | write_r) & ~avm_waitrequest;
    assign last_rx  = (byte_cnt_r == cnt_w'(nbytes - 1));
    assign last_tx  = (byte_cnt_r == cnt_w'(nbytes - 2));

    always_comb begin
        state_w    = state_r;
        byte_cnt_w = byte_cnt_r;
        addr_w     = addr_r;
        read_w     = read_r;
        write_w    = write_r;
        start_w    = 1'b0;
        n_w        = n_r;
        d_w        = d_r;
        enc_w      = enc_r;
        dec_w      = dec_r;

        case (state_r)
            get_key_n, get_key_d, get_data: begin
                read_w = 1'b1;
                if (acc_done) begin
                    if (addr_r == status_base && avm_readdata[rx_ok_bit]) begin
                        addr_w = rx_base;
                    end
                    if (addr_r == rx_base) begin
                        addr_w = status_base;
                        // new byte enters at the low end
                        case (state_r)
                            get_key_n: n_w   = {n_r[bitwidth-9:0], avm_readdata[7:0]};
                            get_key_d: d_w   = {d_r[bitwidth-9:0], avm_readdata[7:0]};
                            default:   enc_w = {enc_r[bitwidth-9:0], avm_readdata[7:0]};
                        endcase
                        if (last_rx) begin
                            byte_cnt_w = '0;
                            case (state_r)
                                get_key_n: state_w = get_key_d;
                                get_key_d: state_w = get_data;
                                default: begin
                                    state_w = req_calc;
                                    read_w  = 1'b0;
                                end
                            endcase
                        end else begin
                            byte_cnt_w = byte_cnt_r + 1'b1;
                        end
                    end
                end
            end
            req_calc: begin
                start_w = 1'b1;
                state_w = wait_calc;
            end
            wait_calc: begin
                if (core_finished) begin
                    dec_w   = core_result;
                    read_w  = 1'b1;  // first tx status poll
                    state_w = send_data;
                end
            end
            default: begin
                if (acc_done) begin
                    if (addr_r == status_base && avm_readdata[tx_ok_bit]) begin
                        addr_w  = tx_base;
                        read_w  = 1'b0;
                        write_w = 1'b1;
                    end
                    if (addr_r == tx_base) begin
                        addr_w  = status_base;
                        write_w = 1'b0;
                        read_w  = 1'b1;
                        dec_w   = dec_r << 8;
                        if (last_tx) begin
                            byte_cnt_w = '0;
                            state_w    = get_data;  // key stays loaded
                        end else begin
                            byte_cnt_w = byte_cnt_r + 1'b1;
                        end
                    end
                end
            end
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r    <= get_key_n;
            byte_cnt_r <= '0;
            addr_r     <= status_base;
            read_r     <= 1'b0;
            write_r    <= 1'b0;
            start_r    <= 1'b0;
        end else begin
            state_r    <= state_w;
            byte_cnt_r <= byte_cnt_w;
            addr_r     <= addr_w;
            read_r     <= read_w;
            write_r    <= write_w;
            start_r    <= start_w;
        end
    end

    always_ff @(posedge avm_clk) begin
        n_r   <= n_w;
        d_r   <= d_w;
        enc_r <= enc_w;
        dec_r <= dec_w;
    end

    rsa_modexp_core #(.bitwidth(bitwidth)) rsa_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start_r),
        .a        (enc_r),
        .d        (d_r),
        .n        (n_r),
        .result   (core_result),
        .finished (core_finished)
    );

endmodule

`default_nettype wire

// ==== rsa_modexp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rsa_modexp_core #(
    parameter int bitwidth = rsa_pkg::default_bitwidth
) (
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [bitwidth-1:0] a,
    input  logic [bitwidth-1:0] d,
    input  logic [bitwidth-1:0] n,
    output logic [bitwidth-1:0] result,
    output logic                finished
);

    localparam int step_w = $clog2(bitwidth);

    typedef enum logic [1:0] {
        core_idle,
        core_setup,  // load multiplier operands
        core_mult,   // one multiplier bit per cycle
        core_store
    } core_state_t;

    core_state_t         state;
    logic                sq_phase;  // 0: res*base, 1: base*base
    logic [step_w-1:0]   step;
    logic [bitwidth-1:0] n_r;
    logic [bitwidth-1:0] d_r;       // shifts right, lsb is next bit
    logic [bitwidth-1:0] base_r;
    logic [bitwidth-1:0] res_r;
    logic [bitwidth-1:0] mx_r;
    logic [bitwidth-1:0] my_r;      // scanned from the msb
    logic [bitwidth+1:0] acc_r;
    logic [bitwidth+1:0] n_ext;
    logic [bitwidth+1:0] dbl;
    logic [bitwidth+1:0] dbl_red;
    logic [bitwidth+1:0] sum;
    logic [bitwidth+1:0] sum_red;

    assign n_ext  = {2'b00, n_r};
    assign result = res_r;

    // interleaved step, acc stays below n after each half
    always_comb begin
        dbl     = {acc_r[bitwidth:0], 1'b0};
        dbl_red = (dbl >= n_ext) ? dbl - n_ext : dbl;
        sum     = dbl_red + (my_r[bitwidth-1] ? {2'b00, mx_r} : '0);
        sum_red = (sum >= n_ext) ? sum - n_ext : sum;
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= core_idle;
            sq_phase <= 1'b0;
            step     <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            case (state)
                core_idle: begin
                    if (start) begin
                        sq_phase <= 1'b0;
                        if (d == '0) begin
                            finished <= 1'b1;  // a^0 is 1
                        end else begin
                            state <= core_setup;
                        end
                    end
                end
                core_setup: begin
                    if (sq_phase || d_r[0]) begin
                        step  <= '0;
                        state <= core_mult;
                    end else begin
                        sq_phase <= 1'b1;  // bit clear, skip the multiply
                    end
                end
                core_mult: begin
                    step <= step + 1'b1;
                    if (step == step_w'(bitwidth - 1)) begin
                        state <= core_store;
                    end
                end
                default: begin
                    if (!sq_phase) begin
                        sq_phase <= 1'b1;
                        state    <= core_setup;
                    end else begin
                        sq_phase <= 1'b0;
                        if (d_r[bitwidth-1:1] == '0) begin
                            finished <= 1'b1;  // no set bits left
                            state    <= core_idle;
                        end else begin
                            state <= core_setup;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            core_idle: begin
                if (start) begin
                    n_r    <= n;
                    d_r    <= d;
                    base_r <= a;
                    res_r  <= bitwidth'(1);
                end
            end
            core_setup: begin
                mx_r  <= sq_phase ? base_r : res_r;
                my_r  <= base_r;
                acc_r <= '0;
            end
            core_mult: begin
                acc_r <= sum_red;
                my_r  <= my_r << 1;
            end
            default: begin
                if (!sq_phase) begin
                    res_r <= acc_r[bitwidth-1:0];
                end else begin
                    base_r <= acc_r[bitwidth-1:0];
                    d_r    <= d_r >> 1;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== serial_port_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_port_regs #(
    parameter int fifo_depth = 4
) (
    input  logic                          avm_clk,
    input  logic                          avm_rst,
    input  logic [avm_pkg::avm_addr_w-1:0] avm_address,
    input  logic                          avm_read,
    input  logic                          avm_write,
    input  logic [31:0]                   avm_writedata,
    output logic [31:0]                   avm_readdata,
    output logic                          avm_waitrequest,
    input  logic [7:0]                    rx_data,
    input  logic                          rx_valid,
    output logic                          rx_ready,
    output logic [7:0]                    tx_data,
    output logic                          tx_valid,
    input  logic                          tx_ready
);
    import avm_pkg::*;

    logic        ack_r;     // second cycle of an access
    logic        acc_done;
    logic        rx_pop;
    logic        tx_push;
    logic        rx_full;
    logic        rx_empty;
    logic        tx_full;
    logic        tx_empty;
    logic [7:0]  rx_head;
    logic [31:0] status_word;

    // every access stalls exactly one cycle
    assign avm_waitrequest = (avm_read | avm_write) & ~ack_r;
    assign acc_done        = (avm_read | avm_write) & ack_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            ack_r <= 1'b0;
        end else begin
            ack_r <= (avm_read | avm_write) & ~ack_r;
        end
    end

    assign rx_pop  = acc_done && avm_read && (avm_address == rx_base);
    assign tx_push = acc_done && avm_write && (avm_address == tx_base);

    always_comb begin
        status_word            = '0;
        status_word[tx_ok_bit] = ~tx_full;
        status_word[rx_ok_bit] = ~rx_empty;
        case (avm_address)
            rx_base:     avm_readdata = {24'd0, rx_head};
            status_base: avm_readdata = status_word;
            default:     avm_readdata = '0;  // tx is write only
        endcase
    end

    assign rx_ready = ~rx_full;
    assign tx_valid = ~tx_empty;

    byte_fifo #(.fifo_depth(fifo_depth)) rx_fifo (
        .avm_clk   (avm_clk),
        .avm_rst   (avm_rst),
        .push      (rx_valid & rx_ready),
        .push_data (rx_data),
        .pop       (rx_pop),
        .pop_data  (rx_head),
        .full      (rx_full),
        .empty     (rx_empty)
    );

    byte_fifo #(.fifo_depth(fifo_depth)) tx_fifo (
        .avm_clk   (avm_clk),
        .avm_rst   (avm_rst),
        .push      (tx_push),
        .push_data (avm_writedata[7:0]),  // only the low byte goes out
        .pop       (tx_valid & tx_ready),
        .pop_data  (tx_data),
        .full      (tx_full),
        .empty     (tx_empty)
    );

endmodule

`default_nettype wire

// ==== byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic       avm_clk,
    input  logic       avm_rst,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] pop_data,
    output logic       full,
    output logic       empty
);

    localparam int idx_w = $clog2(fifo_depth);

    logic [7:0]     mem [fifo_depth];
    logic [idx_w:0] wr_ptr;  // extra msb tells full from empty
    logic [idx_w:0] rd_ptr;
    logic           do_push;
    logic           do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[idx_w] != rd_ptr[idx_w]) &&
                   (wr_ptr[idx_w-1:0] == rd_ptr[idx_w-1:0]);

    // requests against a full or empty buffer are dropped
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign pop_data = mem[rd_ptr[idx_w-1:0]];  // fall-through head

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (do_push) begin
            mem[wr_ptr[idx_w-1:0]] <= push_data;
        end
    end

endmodule

`default_nettype wire

// ==== rsa_pkg.sv ====
`default_nettype none

package rsa_pkg;

    parameter int default_bitwidth = 256;

    // wrapper FSM, key is loaded once and then blocks loop
    typedef enum logic [2:0] {
        get_key_n = 3'd0,
        get_key_d = 3'd1,
        get_data  = 3'd2,
        req_calc  = 3'd3,
        wait_calc = 3'd4,
        send_data = 3'd5
    } wrap_state_t;

endpackage

`default_nettype wire

// ==== avm_pkg.sv ====
`default_nettype none

package avm_pkg;

    // word-aligned byte offsets on the 5-bit Avalon address
    parameter int avm_addr_w = 5;

    parameter logic [avm_addr_w-1:0] rx_base     = 5'd0;  // receive data, pops on read
    parameter logic [avm_addr_w-1:0] tx_base     = 5'd4;  // transmit data, pushes on write
    parameter logic [avm_addr_w-1:0] status_base = 5'd8;

    // status word bits
    parameter int tx_ok_bit = 6;  // tx fifo has room
    parameter int rx_ok_bit = 7;  // rx fifo holds a byte

endpackage

`default_nettype wire
